// ==== axi_burst_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_burst_addr
  import axi_rif_pkg::*;
(
  input  addr_t  i_addr,
  input  burst_t i_burst,
  input  len_t   i_len,
  output addr_t  o_next_addr
);

  // Current address aligned down to a beat
  addr_t aligned;
  // Aligned address plus one beat
  addr_t incr_addr;
  // Byte mask of the wrap window
  addr_t wrap_mask;

  assign aligned   = {i_addr[ADDR_W-1:BEAT_OFF_W], {BEAT_OFF_W{1'b0}}};
  assign incr_addr = aligned + addr_t'(BEAT_BYTES);

  // Window is (len+1) beats, len+1 a power of two for legal WRAP
  assign wrap_mask = addr_t'({i_len, {BEAT_OFF_W{1'b1}}});

  always_comb begin
    case (i_burst)
      BURST_INCR: begin
        o_next_addr = incr_addr;
      end
      BURST_WRAP: begin
        // Keep the window base, step the offset inside it
        o_next_addr = (aligned & ~wrap_mask) | (incr_addr & wrap_mask);
      end
      // FIXED and the reserved code stay put
      default: begin
        o_next_addr = i_addr;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== axi_rif_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rif_adapter
  import axi_rif_pkg::*;
(
  input  logic   aclk,
  input  logic   aresetn,
  // AW channel
  input  id_t    i_awid,
  input  addr_t  i_awaddr,
  input  len_t   i_awlen,
  input  burst_t i_awburst,
  input  logic   i_awvalid,
  output logic   o_awready,
  // W channel
  input  data_t  i_wdata,
  input  strb_t  i_wstrb,
  input  logic   i_wlast,
  input  logic   i_wvalid,
  output logic   o_wready,
  // B channel
  output id_t    o_bid,
  output resp_t  o_bresp,
  output logic   o_bvalid,
  input  logic   i_bready,
  // AR channel
  input  id_t    i_arid,
  input  addr_t  i_araddr,
  input  len_t   i_arlen,
  input  burst_t i_arburst,
  input  logic   i_arvalid,
  output logic   o_arready,
  // R channel
  output id_t    o_rid,
  output data_t  o_rdata,
  output resp_t  o_rresp,
  output logic   o_rlast,
  output logic   o_rvalid,
  input  logic   i_rready,
  // RIF write side
  output logic   o_rif_wr_req,
  output addr_t  o_rif_waddr,
  output data_t  o_rif_wdata,
  output strb_t  o_rif_wstrb,
  input  logic   i_rif_wack,
  // RIF read side
  output logic   o_rif_rd_req,
  output addr_t  o_rif_raddr,
  input  data_t  i_rif_rdata,
  input  logic   i_rif_rack
);

  // Write path, AW W B into RIF writes
  axi_rif_write u_write (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .i_awid       (i_awid),
    .i_awaddr     (i_awaddr),
    .i_awlen      (i_awlen),
    .i_awburst    (i_awburst),
    .i_awvalid    (i_awvalid),
    .o_awready    (o_awready),
    .i_wdata      (i_wdata),
    .i_wstrb      (i_wstrb),
    .i_wlast      (i_wlast),
    .i_wvalid     (i_wvalid),
    .o_wready     (o_wready),
    .o_bid        (o_bid),
    .o_bresp      (o_bresp),
    .o_bvalid     (o_bvalid),
    .i_bready     (i_bready),
    .o_rif_wr_req (o_rif_wr_req),
    .o_rif_waddr  (o_rif_waddr),
    .o_rif_wdata  (o_rif_wdata),
    .o_rif_wstrb  (o_rif_wstrb),
    .i_rif_wack   (i_rif_wack)
  );

  // Read path runs independently of writes
  axi_rif_read u_read (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .i_arid       (i_arid),
    .i_araddr     (i_araddr),
    .i_arlen      (i_arlen),
    .i_arburst    (i_arburst),
    .i_arvalid    (i_arvalid),
    .o_arready    (o_arready),
    .o_rid        (o_rid),
    .o_rdata      (o_rdata),
    .o_rresp      (o_rresp),
    .o_rlast      (o_rlast),
    .o_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .o_rif_rd_req (o_rif_rd_req),
    .o_rif_raddr  (o_rif_raddr),
    .i_rif_rdata  (i_rif_rdata),
    .i_rif_rack   (i_rif_rack)
  );

endmodule

`default_nettype wire

// ==== axi_rif_pkg.sv ====
`default_nettype none

package axi_rif_pkg;

  // --------------------
  // Bus widths
  // --------------------

  // Byte address width
  localparam int ADDR_W = 12;
  // Data bus width
  localparam int DATA_W = 32;
  // One strobe bit per byte
  localparam int STRB_W = DATA_W / 8;
  // AXI ID width
  localparam int ID_W = 4;

  // Bytes per beat, always full bus width
  localparam int BEAT_BYTES = STRB_W;
  // Low address bits inside one beat
  localparam int BEAT_OFF_W = $clog2(BEAT_BYTES);

  // --------------------
  // AXI encodings
  // --------------------

  // AxBURST codes
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  // xRESP codes, only these two are ever returned
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // --------------------
  // Types
  // --------------------

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [ID_W-1:0]   id_t;
  // AXI length, beats minus one
  typedef logic [7:0]        len_t;
  typedef logic [1:0]        burst_t;
  typedef logic [1:0]        resp_t;

endpackage

`default_nettype wire

// ==== axi_rif_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rif_read
  import axi_rif_pkg::*;
(
  input  logic   aclk,
  input  logic   aresetn,
  // AR channel
  input  id_t    i_arid,
  input  addr_t  i_araddr,
  input  len_t   i_arlen,
  input  burst_t i_arburst,
  input  logic   i_arvalid,
  output logic   o_arready,
  // R channel
  output id_t    o_rid,
  output data_t  o_rdata,
  output resp_t  o_rresp,
  output logic   o_rlast,
  output logic   o_rvalid,
  input  logic   i_rready,
  // RIF read side
  output logic   o_rif_rd_req,
  output addr_t  o_rif_raddr,
  input  data_t  i_rif_rdata,
  input  logic   i_rif_rack
);

  // Channel handshakes
  logic       ar_hs;
  logic       r_hs;

  // Latched AR fields
  id_t        arid_q;
  len_t       arlen_q;
  burst_t     arburst_q;

  // Beats still to request, up to 256
  logic [8:0] beats_left;

  // Address of the next beat to request
  addr_t      raddr;
  addr_t      next_raddr;

  // R register can take a beat this cycle
  logic       r_free;
  logic       rd_req;

  assign ar_hs  = i_arvalid & o_arready;
  assign r_hs   = o_rvalid & i_rready;
  assign r_free = ~o_rvalid | i_rready;

  // Request while a burst is active and beats remain
  assign rd_req = ~o_arready & (beats_left != 9'd0) & r_free;

  // --------------------
  // AR and beat count
  // --------------------

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      o_arready  <= 1'b1;
      beats_left <= 9'd0;
    end else begin
      // AR stays closed until the last beat leaves R
      if (ar_hs) begin
        o_arready <= 1'b0;
      end else if (r_hs && o_rlast) begin
        o_arready <= 1'b1;
      end
      if (ar_hs) begin
        beats_left <= {1'b0, i_arlen} + 9'd1;
      end else if (rd_req) begin
        beats_left <= beats_left - 9'd1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ar_hs) begin
      arid_q    <= i_arid;
      arlen_q   <= i_arlen;
      arburst_q <= i_arburst;
      raddr     <= i_araddr;
    end else if (rd_req) begin
      raddr     <= next_raddr;
    end
  end

  axi_burst_addr u_raddr_step (
    .i_addr      (raddr),
    .i_burst     (arburst_q),
    .i_len       (arlen_q),
    .o_next_addr (next_raddr)
  );

  // --------------------
  // R output register
  // --------------------

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      o_rvalid <= 1'b0;
      o_rlast  <= 1'b0;
    end else if (rd_req) begin
      o_rvalid <= 1'b1;
      // Final beat is the one requested at count one
      o_rlast  <= (beats_left == 9'd1);
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  // Undecoded beat returns zero with SLVERR
  always_ff @(posedge aclk) begin
    if (rd_req) begin
      o_rdata <= i_rif_rack ? i_rif_rdata : '0;
      o_rresp <= i_rif_rack ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // --------------------
  // Outputs
  // --------------------

  assign o_rid        = arid_q;
  assign o_rif_rd_req = rd_req;
  assign o_rif_raddr  = raddr;

endmodule

`default_nettype wire

// ==== axi_rif_write.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rif_write
  import axi_rif_pkg::*;
(
  input  logic   aclk,
  input  logic   aresetn,
  // AW channel
  input  id_t    i_awid,
  input  addr_t  i_awaddr,
  input  len_t   i_awlen,
  input  burst_t i_awburst,
  input  logic   i_awvalid,
  output logic   o_awready,
  // W channel
  input  data_t  i_wdata,
  input  strb_t  i_wstrb,
  input  logic   i_wlast,
  input  logic   i_wvalid,
  output logic   o_wready,
  // B channel
  output id_t    o_bid,
  output resp_t  o_bresp,
  output logic   o_bvalid,
  input  logic   i_bready,
  // RIF write side
  output logic   o_rif_wr_req,
  output addr_t  o_rif_waddr,
  output data_t  o_rif_wdata,
  output strb_t  o_rif_wstrb,
  input  logic   i_rif_wack
);

  // Channel handshakes
  logic   aw_hs;
  logic   w_hs;
  logic   b_hs;

  // Latched AW fields
  id_t    awid_q;
  len_t   awlen_q;
  burst_t awburst_q;

  // Address of the beat now accepted on W
  addr_t  waddr;
  addr_t  next_waddr;

  // Sticky decode error of the burst
  logic   wr_err;

  assign aw_hs = i_awvalid & o_awready;
  assign w_hs  = i_wvalid & o_wready;
  assign b_hs  = o_bvalid & i_bready;

  // --------------------
  // Channel control
  // --------------------

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      o_awready <= 1'b1;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
    end else begin
      // AW closes for the whole burst, reopens after B
      if (aw_hs) begin
        o_awready <= 1'b0;
      end else if (b_hs) begin
        o_awready <= 1'b1;
      end
      // W open from AW until the wlast beat
      if (aw_hs) begin
        o_wready <= 1'b1;
      end else if (w_hs && i_wlast) begin
        o_wready <= 1'b0;
      end
      // B follows the last beat
      if (w_hs && i_wlast) begin
        o_bvalid <= 1'b1;
      end else if (b_hs) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  // Missing acks accumulate, a new burst starts clean
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_err <= 1'b0;
    end else if (aw_hs) begin
      wr_err <= 1'b0;
    end else if (w_hs && !i_rif_wack) begin
      wr_err <= 1'b1;
    end
  end

  // --------------------
  // Burst address
  // --------------------

  always_ff @(posedge aclk) begin
    if (aw_hs) begin
      awid_q    <= i_awid;
      awlen_q   <= i_awlen;
      awburst_q <= i_awburst;
      waddr     <= i_awaddr;
    end else if (w_hs) begin
      waddr     <= next_waddr;
    end
  end

  axi_burst_addr u_waddr_step (
    .i_addr      (waddr),
    .i_burst     (awburst_q),
    .i_len       (awlen_q),
    .o_next_addr (next_waddr)
  );

  // --------------------
  // Outputs
  // --------------------

  // One RIF write per W transfer
  assign o_rif_wr_req = w_hs;
  assign o_rif_waddr  = waddr;
  assign o_rif_wdata  = i_wdata;
  assign o_rif_wstrb  = i_wstrb;

  // ID echoed from AW
  assign o_bid   = awid_q;
  assign o_bresp = wr_err ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the AXI to RIF adapter testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert --top-module tb_axi_rif_adapter -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running after an assertion error so the testbench can report it
out=$(./obj_dir/Vtb_axi_rif_adapter +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

// ==== sim.f ====
axi_rif_pkg.sv
axi_burst_addr.sv
axi_rif_write.sv
axi_rif_read.sv
axi_rif_adapter.sv
tb_clk_gen.sv
tb_axi_rif_sva.sv
tb_axi_rif_adapter.sv

// ==== tb_axi_rif_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rif_adapter
  import axi_rif_pkg::*;
();

  localparam int CLK_PERIOD_NS = 100;
  localparam int SEED          = 32'h4a48_b627;
  localparam int MEM_WORDS     = 64;
  // Word index from here up is undecoded
  localparam int N_DECODED     = 48;
  localparam int N_WR          = 16;
  localparam int N_RD          = 16;
  localparam int N_PAIR        = 8;
  localparam int N_BURSTS      = N_WR + N_RD + 2 * N_PAIR;
  localparam int TIMEOUT_NS    = N_BURSTS * 300 * CLK_PERIOD_NS;

  logic   aclk;
  logic   aresetn;
  id_t    i_awid;
  addr_t  i_awaddr;
  len_t   i_awlen;
  burst_t i_awburst;
  logic   i_awvalid;
  logic   o_awready;
  data_t  i_wdata;
  strb_t  i_wstrb;
  logic   i_wlast;
  logic   i_wvalid;
  logic   o_wready;
  id_t    o_bid;
  resp_t  o_bresp;
  logic   o_bvalid;
  logic   i_bready;
  id_t    i_arid;
  addr_t  i_araddr;
  len_t   i_arlen;
  burst_t i_arburst;
  logic   i_arvalid;
  logic   o_arready;
  id_t    o_rid;
  data_t  o_rdata;
  resp_t  o_rresp;
  logic   o_rlast;
  logic   o_rvalid;
  logic   i_rready;
  logic   o_rif_wr_req;
  addr_t  o_rif_waddr;
  data_t  o_rif_wdata;
  strb_t  o_rif_wstrb;
  logic   i_rif_wack;
  logic   o_rif_rd_req;
  addr_t  o_rif_raddr;
  data_t  i_rif_rdata;
  logic   i_rif_rack;

  // Register file seen by the DUT, and the expected contents
  data_t  rif_mem [MEM_WORDS];
  data_t  ref_mem [MEM_WORDS];
  // Expected RIF writes in issue order
  addr_t  exp_waddr_q [$];
  data_t  exp_wdata_q [$];
  strb_t  exp_wstrb_q [$];
  // Expected RIF read addresses in issue order
  addr_t  exp_raddr_q [$];
  int     errors = 0;
  int     checks = 0;
  int     r_seen = 0;
  int     r_expected = 0;
  int     total_errors;

  tb_clk_gen u_clk_gen (
    .o_aclk    (aclk),
    .o_aresetn (aresetn)
  );

  axi_rif_adapter DUT (.*);

  bind axi_rif_adapter tb_axi_rif_sva u_sva (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .i_wvalid     (i_wvalid),
    .i_wready     (o_wready),
    .i_bvalid     (o_bvalid),
    .i_bready     (i_bready),
    .i_bid        (o_bid),
    .i_bresp      (o_bresp),
    .i_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .i_rdata      (o_rdata),
    .i_rresp      (o_rresp),
    .i_rlast      (o_rlast),
    .i_rif_wr_req (o_rif_wr_req),
    .i_rif_rd_req (o_rif_rd_req)
  );

  // --------------------
  // Register-file model
  // --------------------

  function automatic logic decoded(input addr_t a);
    return (a >> BEAT_OFF_W) < addr_t'(N_DECODED);
  endfunction

  function automatic data_t fill_word(input int w);
    return data_t'(w) * 32'h9e37_79b1 + 32'h0f1e_2d3c;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
    data_t m;
    m = old;
    for (int k = 0; k < STRB_W; k++) begin
      if (strb[k]) begin
        m[8*k +: 8] = wdata[8*k +: 8];
      end
    end
    return m;
  endfunction

  // Same-cycle answers, no back-pressure
  assign i_rif_wack  = decoded(o_rif_waddr);
  assign i_rif_rack  = decoded(o_rif_raddr);
  assign i_rif_rdata = decoded(o_rif_raddr) ? rif_mem[o_rif_raddr[7:2]] : '0;

  always @(posedge aclk) begin
    if (!aresetn) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        rif_mem[w] <= fill_word(w);
      end
    end else if (o_rif_wr_req && decoded(o_rif_waddr)) begin
      rif_mem[o_rif_waddr[7:2]] <= merge_bytes(rif_mem[o_rif_waddr[7:2]], o_rif_wdata,
                                               o_rif_wstrb);
    end
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic bit chance(input int pct);
    return $urandom_range(99, 0) < pct;
  endfunction

  // Expected address of beat i, from the AXI burst rules
  function automatic addr_t beat_addr(input addr_t start, input burst_t b, input len_t len,
                                      input int i);
    int span;
    int base;
    span = (int'(len) + 1) * BEAT_BYTES;
    base = int'(start) - (int'(start) % span);
    case (b)
      BURST_FIXED: return start;
      BURST_WRAP:  return addr_t'(base + (int'(start) - base + i * BEAT_BYTES) % span);
      default:     return addr_t'(int'(start) + i * BEAT_BYTES);
    endcase
  endfunction

  task automatic expect_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic check_rif_write();
    if (exp_waddr_q.size() == 0) begin
      errors++;
      $display("Error at time %0t: RIF write issued with no W beat outstanding", $time);
    end else begin
      expect_eq("rif_waddr", 64'(o_rif_waddr), 64'(exp_waddr_q.pop_front()));
      expect_eq("rif_wdata", 64'(o_rif_wdata), 64'(exp_wdata_q.pop_front()));
      expect_eq("rif_wstrb", 64'(o_rif_wstrb), 64'(exp_wstrb_q.pop_front()));
    end
  endtask

  task automatic check_rif_read();
    if (exp_raddr_q.size() == 0) begin
      errors++;
      $display("Error at time %0t: RIF read issued with no R beat outstanding", $time);
    end else begin
      expect_eq("rif_raddr", 64'(o_rif_raddr), 64'(exp_raddr_q.pop_front()));
    end
  endtask

  // Burst that stays inside words lo..hi, except the long INCR
  task automatic pick_burst(input int lo, input int hi, output burst_t b, output len_t len,
                            output addr_t start);
    int word;
    case ($urandom_range(2, 0))
      0: begin
        b    = BURST_FIXED;
        len  = len_t'($urandom_range(15, 0));
        word = int'($urandom_range(hi, lo));
      end
      1: begin
        // 2, 4, 8 or 16 beats
        b    = BURST_WRAP;
        len  = len_t'((2 << $urandom_range(3, 0)) - 1);
        word = int'($urandom_range(hi, lo));
      end
      default: begin
        b = BURST_INCR;
        if (hi - lo >= MEM_WORDS - 1 && chance(10)) begin
          len  = 8'd255;
          word = int'($urandom_range(hi, lo));
        end else begin
          len  = len_t'($urandom_range(15, 0));
          word = int'($urandom_range(hi - int'(len), lo));
        end
      end
    endcase
    start = addr_t'(word * BEAT_BYTES);
  endtask

  // --------------------
  // Bursts
  // --------------------

  task automatic write_burst(input int lo, input int hi);
    burst_t b;
    len_t   len;
    addr_t  start;
    addr_t  a;
    id_t    id;
    data_t  d;
    strb_t  s;
    logic   err;
    pick_burst(lo, hi, b, len, start);
    id  = id_t'($urandom);
    err = 1'b0;
    @(negedge aclk);
    while (chance(30)) @(negedge aclk);
    i_awid    = id;
    i_awaddr  = start;
    i_awlen   = len;
    i_awburst = b;
    i_awvalid = 1'b1;
    while (!o_awready) @(negedge aclk);
    @(negedge aclk);
    i_awvalid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      i_wvalid = 1'b0;
      while (chance(25)) @(negedge aclk);
      a = beat_addr(start, b, len, i);
      d = data_t'($urandom);
      s = strb_t'($urandom);
      exp_waddr_q.push_back(a);
      exp_wdata_q.push_back(d);
      exp_wstrb_q.push_back(s);
      if (decoded(a)) begin
        ref_mem[a[7:2]] = merge_bytes(ref_mem[a[7:2]], d, s);
      end else begin
        err = 1'b1;
      end
      i_wdata  = d;
      i_wstrb  = s;
      i_wlast  = (i == int'(len));
      i_wvalid = 1'b1;
      while (!o_wready) @(negedge aclk);
      @(negedge aclk);
    end
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
    // Random bready until B is taken
    i_bready = chance(60);
    while (!(o_bvalid && i_bready)) begin
      @(negedge aclk);
      i_bready = chance(60);
    end
    expect_eq("bid", 64'(o_bid), 64'(id));
    expect_eq("bresp", 64'(o_bresp), 64'(err ? RESP_SLVERR : RESP_OKAY));
  endtask

  task automatic read_burst(input int lo, input int hi);
    burst_t b;
    len_t   len;
    addr_t  start;
    addr_t  a;
    id_t    id;
    int     i;
    pick_burst(lo, hi, b, len, start);
    id = id_t'($urandom);
    r_expected += int'(len) + 1;
    for (int k = 0; k <= int'(len); k++) begin
      exp_raddr_q.push_back(beat_addr(start, b, len, k));
    end
    @(negedge aclk);
    while (chance(30)) @(negedge aclk);
    i_arid    = id;
    i_araddr  = start;
    i_arlen   = len;
    i_arburst = b;
    i_arvalid = 1'b1;
    while (!o_arready) @(negedge aclk);
    @(negedge aclk);
    i_arvalid = 1'b0;
    i = 0;
    while (i <= int'(len)) begin
      i_rready = chance(70);
      // Beat moves on the coming rising edge
      if (o_rvalid && i_rready) begin
        a = beat_addr(start, b, len, i);
        expect_eq("rdata", 64'(o_rdata), 64'(decoded(a) ? ref_mem[a[7:2]] : '0));
        expect_eq("rresp", 64'(o_rresp), 64'(decoded(a) ? RESP_OKAY : RESP_SLVERR));
        expect_eq("rlast", 64'(o_rlast), 64'(i == int'(len)));
        expect_eq("rid", 64'(o_rid), 64'(id));
        i++;
      end
      @(negedge aclk);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    void'($urandom(SEED));
    i_awid    = '0;
    i_awaddr  = '0;
    i_awlen   = '0;
    i_awburst = BURST_INCR;
    i_awvalid = 1'b0;
    i_wdata   = '0;
    i_wstrb   = '0;
    i_wlast   = 1'b0;
    i_wvalid  = 1'b0;
    i_bready  = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_arburst = BURST_INCR;
    i_arvalid = 1'b0;
    i_rready  = 1'b0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      ref_mem[w] = fill_word(w);
    end
    // RIF request and R beat monitor
    fork
      forever begin
        @(posedge aclk);
        if (aresetn && o_rif_wr_req) begin
          check_rif_write();
        end
        if (aresetn && o_rif_rd_req) begin
          check_rif_read();
        end
        if (aresetn && o_rvalid && i_rready) begin
          r_seen++;
        end
      end
    join_none
    @(posedge aresetn);
    @(negedge aclk);
    expect_eq("awready after reset", 64'(o_awready), 64'(1));
    expect_eq("wready after reset", 64'(o_wready), 64'(0));
    expect_eq("bvalid after reset", 64'(o_bvalid), 64'(0));
    expect_eq("arready after reset", 64'(o_arready), 64'(1));
    expect_eq("rvalid after reset", 64'(o_rvalid), 64'(0));
    expect_eq("rif_wr_req after reset", 64'(o_rif_wr_req), 64'(0));
    expect_eq("rif_rd_req after reset", 64'(o_rif_rd_req), 64'(0));
    for (int n = 0; n < N_WR; n++) begin
      write_burst(0, MEM_WORDS - 1);
    end
    for (int n = 0; n < N_RD; n++) begin
      read_burst(0, MEM_WORDS - 1);
    end
    // Overlapping write and read on disjoint words
    for (int n = 0; n < N_PAIR; n++) begin
      fork
        write_burst(0, 31);
        read_burst(32, MEM_WORDS - 1);
      join
    end
    repeat (4) @(negedge aclk);
    expect_eq("RIF writes left over", 64'(exp_waddr_q.size()), 64'(0));
    expect_eq("RIF reads left over", 64'(exp_raddr_q.size()), 64'(0));
    expect_eq("R beats delivered", 64'(r_seen), 64'(r_expected));
    total_errors = errors + DUT.u_sva.b_fails + DUT.u_sva.r_fails + DUT.u_sva.wreq_fails
                   + DUT.u_sva.rreq_fails;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             total_errors - errors);
    if (total_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: bursts still running after %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_axi_rif_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rif_sva
  import axi_rif_pkg::*;
(
  input logic  aclk,
  input logic  aresetn,
  input logic  i_wvalid,
  input logic  i_wready,
  input logic  i_bvalid,
  input logic  i_bready,
  input id_t   i_bid,
  input resp_t i_bresp,
  input logic  i_rvalid,
  input logic  i_rready,
  input data_t i_rdata,
  input resp_t i_rresp,
  input logic  i_rlast,
  input logic  i_rif_wr_req,
  input logic  i_rif_rd_req
);

  // Failure counts, summed by the testbench top
  int b_fails    = 0;
  int r_fails    = 0;
  int wreq_fails = 0;
  int rreq_fails = 0;

  // B held with stable payload until bready
  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    i_bvalid && !i_bready |=> i_bvalid && $stable(i_bid) && $stable(i_bresp))
  else begin
    b_fails++;
    $error("B channel dropped or changed before bready");
  end

  // R held with stable payload while stalled
  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp)
      && $stable(i_rlast))
  else begin
    r_fails++;
    $error("R channel dropped or changed while rready low");
  end

  // RIF write only on a W transfer
  a_wreq: assert property (@(posedge aclk) disable iff (!aresetn)
    i_rif_wr_req |-> i_wvalid && i_wready)
  else begin
    wreq_fails++;
    $error("RIF write issued without a W transfer");
  end

  // No RIF read while R is stalled
  a_rreq: assert property (@(posedge aclk) disable iff (!aresetn)
    i_rvalid && !i_rready |-> !i_rif_rd_req)
  else begin
    rreq_fails++;
    $error("RIF read issued under R back-pressure");
  end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic o_aclk,
  output logic o_aresetn
);

  // 100 ns period
  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES   = 4;

  initial begin
    o_aclk = 1'b0;
    forever #HALF_PERIOD_NS o_aclk = ~o_aclk;
  end

  // Release on a falling edge, in step with the stimulus
  initial begin
    o_aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_aclk);
    @(negedge o_aclk);
    o_aresetn = 1'b1;
  end

endmodule

`default_nettype wire
